//--- common/id_params.svh
/*
 * Decode stage parameters
 * Data and register index widths, and the RV32I major opcodes of the subset.
 */

`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

`define ID_XLEN       32
`define ID_REG_ADDR_W 5
`define ID_NUM_REGS   32

// Major opcodes, instr[6:0]
`define ID_OPC_OP     7'h33
`define ID_OPC_OPIMM  7'h13
`define ID_OPC_LUI    7'h37
`define ID_OPC_AUIPC  7'h17
`define ID_OPC_LOAD   7'h03
`define ID_OPC_STORE  7'h23
`define ID_OPC_BRANCH 7'h63

`endif

//--- common/id_pkg.sv
/*
 * Decode stage package
 * Word and index types, selector encodings and the request structs.
 */

`include "id_params.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]       word_t;
  typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

  // ALU operators, compare ops come last
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U} imm_b_sel_e;
  typedef enum logic       {RF_WD_EX, RF_WD_LSU} rf_wd_sel_e;

  typedef enum logic [1:0] {
    LSU_WORD = 2'd0,
    LSU_HALF = 2'd1,
    LSU_BYTE = 2'd2
  } lsu_type_e;

  typedef enum logic {IDLE, WAIT_MULTICYCLE} wb_state_e;

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    logic       rf_we;
    rf_wd_sel_e rf_wd_sel;
    logic       data_req;
    logic       data_we;
    lsu_type_e  data_type;
    logic       data_sign_ext;
    logic       branch;
  } dec_ctrl_t;

  // Sign-extended immediates, one per format
  typedef struct packed {
    word_t i_type;
    word_t s_type;
    word_t b_type;
    word_t u_type;
  } imm_set_t;

  typedef struct packed {
    alu_op_e operator;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

  typedef struct packed {
    logic      req;
    logic      we;
    lsu_type_e data_type;
    logic      sign_ext;
    word_t     wdata;
  } lsu_req_t;

endpackage

//--- decoder/id_decoder.sv
/*
 * Instruction decoder
 * Turns an RV32I word into ALU, LSU and writeback controls, the register
 * addresses and the four sign-extended immediates.
 */

`timescale 1ns/1ps

`include "id_params.svh"

module id_decoder (
  input  id_pkg::word_t     instr_rdata_i,
  output id_pkg::dec_ctrl_t ctrl_o,
  output id_pkg::imm_set_t  imm_o,
  output id_pkg::reg_addr_t raddr_a_o,
  output id_pkg::reg_addr_t raddr_b_o,
  output id_pkg::reg_addr_t waddr_o,
  output logic              illegal_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  assign raddr_a_o = instr_rdata_i[19:15];
  assign raddr_b_o = instr_rdata_i[24:20];
  assign waddr_o   = instr_rdata_i[11:7];

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////////////////////

  assign imm_o.i_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_o.s_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_o.b_type = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                         instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_o.u_type = {instr_rdata_i[31:12], 12'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_o = '{alu_op: ALU_ADD, op_a_sel: OP_A_REG_A, op_b_sel: OP_B_REG_B,
               imm_b_sel: IMM_B_I, rf_we: 1'b0, rf_wd_sel: RF_WD_EX,
               data_req: 1'b0, data_we: 1'b0, data_type: LSU_WORD,
               data_sign_ext: 1'b0, branch: 1'b0};
    illegal_o = 1'b0;

    unique case (opcode)
      `ID_OPC_OP: begin
        ctrl_o.rf_we = 1'b1;
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: ctrl_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: ctrl_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: ctrl_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: ctrl_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: ctrl_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: ctrl_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: ctrl_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: ctrl_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: ctrl_o.alu_op = ALU_AND;
          default:         illegal_o = 1'b1;
        endcase
      end

      `ID_OPC_OPIMM: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        unique case (funct3)
          3'b000: ctrl_o.alu_op = ALU_ADD;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b110: ctrl_o.alu_op = ALU_OR;
          3'b111: ctrl_o.alu_op = ALU_AND;
          3'b001: begin
            ctrl_o.alu_op = ALU_SLL;
            illegal_o     = (funct7 != 7'h00);
          end
          3'b101: begin
            // Shift kind sits in imm[11:5]
            ctrl_o.alu_op = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            illegal_o     = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
          default: illegal_o = 1'b1;
        endcase
      end

      `ID_OPC_LUI, `ID_OPC_AUIPC: begin
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = (opcode == `ID_OPC_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMM_B_U;
      end

      `ID_OPC_LOAD, `ID_OPC_STORE: begin
        // The ALU forms the address rs1 + imm
        ctrl_o.op_b_sel      = OP_B_IMM;
        ctrl_o.data_req      = 1'b1;
        ctrl_o.data_sign_ext = ~funct3[2];
        if (opcode == `ID_OPC_STORE) begin
          ctrl_o.imm_b_sel = IMM_B_S;
          ctrl_o.data_we   = 1'b1;
          illegal_o        = funct3[2];
        end else begin
          ctrl_o.rf_we     = 1'b1;
          ctrl_o.rf_wd_sel = RF_WD_LSU;
        end
        unique case (funct3[1:0])
          2'b00:   ctrl_o.data_type = LSU_BYTE;
          2'b01:   ctrl_o.data_type = LSU_HALF;
          2'b10:   ctrl_o.data_type = LSU_WORD;
          default: illegal_o = 1'b1;
        endcase
        // No unsigned word load in RV32I
        if (funct3 == 3'b110) begin
          illegal_o = 1'b1;
        end
      end

      `ID_OPC_BRANCH: begin
        ctrl_o.branch    = 1'b1;
        ctrl_o.imm_b_sel = IMM_B_B;
        unique case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end

      default: illegal_o = 1'b1;
    endcase

    // Nothing may leave the stage for an unsupported encoding
    if (illegal_o) begin
      ctrl_o.rf_we    = 1'b0;
      ctrl_o.data_req = 1'b0;
      ctrl_o.branch   = 1'b0;
    end
  end

  // The FSM handles one multicycle kind at a time
  always_comb begin
    a_multicycle_onehot: assert final ($onehot0({ctrl_o.data_req, ctrl_o.branch}))
      else $error("decoder flags both a memory access and a branch");
  end

endmodule

//--- logic/id_operand_mux.sv
/*
 * Operand mux
 * Picks the immediate and both ALU operands, and forms the ALU and LSU requests.
 */

`timescale 1ns/1ps

module id_operand_mux (
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::imm_set_t  imm_i,
  input  id_pkg::word_t     rdata_a_i,
  input  id_pkg::word_t     rdata_b_i,
  input  id_pkg::word_t     pc_i,
  input  logic              executing_i,
  output id_pkg::alu_req_t  alu_req_o,
  output id_pkg::lsu_req_t  lsu_req_o
);

  import id_pkg::*;

  word_t imm_b;

  always_comb begin
    unique case (ctrl_i.imm_b_sel)
      IMM_B_I: imm_b = imm_i.i_type;
      IMM_B_S: imm_b = imm_i.s_type;
      IMM_B_B: imm_b = imm_i.b_type;
      IMM_B_U: imm_b = imm_i.u_type;
      default: imm_b = imm_i.i_type;
    endcase
  end

  // Operand A, zero source serves LUI
  always_comb begin
    unique case (ctrl_i.op_a_sel)
      OP_A_REG_A:  alu_req_o.operand_a = rdata_a_i;
      OP_A_CURRPC: alu_req_o.operand_a = pc_i;
      OP_A_ZERO:   alu_req_o.operand_a = '0;
      default:     alu_req_o.operand_a = '0;
    endcase
  end

  assign alu_req_o.operand_b = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_b : rdata_b_i;
  assign alu_req_o.operator  = ctrl_i.alu_op;

  // Store data always comes from rs2
  assign lsu_req_o.req       = ctrl_i.data_req & executing_i;
  assign lsu_req_o.we        = ctrl_i.data_we;
  assign lsu_req_o.data_type = ctrl_i.data_type;
  assign lsu_req_o.sign_ext  = ctrl_i.data_sign_ext;
  assign lsu_req_o.wdata     = rdata_b_i;

  always_comb begin
    a_imm_sel_known: assert final (!$isunknown(ctrl_i.imm_b_sel))
      else $error("immediate select is unknown");
  end

endmodule

//--- logic/id_register_file.sv
/*
 * Register file
 * 32 x 32 flip-flops, two combinational read ports, one write port, x0 is zero.
 */

`timescale 1ns/1ps

`include "id_params.svh"

module id_register_file (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  id_pkg::reg_addr_t raddr_a_i,
  input  id_pkg::reg_addr_t raddr_b_i,
  input  id_pkg::reg_addr_t waddr_i,
  input  id_pkg::word_t     wdata_i,
  input  logic              we_i,
  output id_pkg::word_t     rdata_a_o,
  output id_pkg::word_t     rdata_b_o
);

  import id_pkg::*;

  word_t rf_q [`ID_NUM_REGS];

  // Entry 0 is cleared by reset and never written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `ID_NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `ID_NUM_REGS; i++) begin
        if (we_i && (waddr_i == reg_addr_t'(i))) begin
          rf_q[i] <= wdata_i;
        end
      end
    end
  end

  // Old data in the write cycle, no bypass
  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];

endmodule

//--- logic/id_wb_control.sv
/*
 * Writeback control
 * Holds loads, stores and taken branches until completion, gates register
 * writes, registers the branch set and flags retirement.
 */

`timescale 1ns/1ps

module id_wb_control (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_valid_i,
  input  logic              instr_new_i,
  input  logic              illegal_i,
  input  logic              branch_decision_i,
  input  logic              ex_valid_i,
  input  logic              lsu_valid_i,
  input  logic              lsu_load_err_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::word_t     wdata_ex_i,
  input  id_pkg::word_t     wdata_lsu_i,
  output logic              rf_we_o,
  output id_pkg::word_t     rf_wdata_o,
  output logic              executing_o,
  output logic              branch_set_o,
  output logic              id_ready_o,
  output logic              instr_ret_o,
  output logic              illegal_insn_o
);

  import id_pkg::*;

  wb_state_e state_q, state_d;
  logic      done_q, done_d;
  logic      branch_set_d;
  logic      rf_we_wb;
  logic      multicycle;

  assign multicycle  = ctrl_i.data_req | ctrl_i.branch;
  // Done flag stops a held multicycle instruction from issuing again
  assign executing_o = instr_new_i | (multicycle & ~done_q);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    done_d       = done_q;
    branch_set_d = 1'b0;
    rf_we_wb     = 1'b0;
    instr_ret_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (instr_new_i) begin
          if (ctrl_i.data_req) begin
            state_d = WAIT_MULTICYCLE;
            done_d  = 1'b0;
          end else if (ctrl_i.branch) begin
            // Not taken retires at once
            state_d      = branch_decision_i ? WAIT_MULTICYCLE : IDLE;
            done_d       = ~branch_decision_i;
            branch_set_d = branch_decision_i;
            instr_ret_o  = ~branch_decision_i;
          end else begin
            instr_ret_o = ~illegal_i;
          end
        end
      end

      WAIT_MULTICYCLE: begin
        if ((ctrl_i.data_req & lsu_valid_i) | (~ctrl_i.data_req & ex_valid_i)) begin
          state_d     = IDLE;
          done_d      = 1'b1;
          rf_we_wb    = ctrl_i.rf_we & ~lsu_load_err_i;
          instr_ret_o = 1'b1;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      done_q       <= 1'b1;
      branch_set_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      done_q       <= done_d;
      branch_set_o <= branch_set_d;
    end
  end

  assign id_ready_o = (state_d == IDLE);

  // Loads write at completion only
  assign rf_we_o    = executing_o & (ctrl_i.data_req ? rf_we_wb : ctrl_i.rf_we);
  assign rf_wdata_o = (ctrl_i.rf_wd_sel == RF_WD_LSU) ? wdata_lsu_i : wdata_ex_i;

  assign illegal_insn_o = instr_valid_i & illegal_i;

  a_state_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_q))
    else $error("writeback state is unknown");

  // EX must resolve the condition whenever a new branch is decoded
  a_branch_decision_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_new_i && ctrl_i.branch) |-> !$isunknown(branch_decision_i))
    else $error("branch decision unknown on a new branch");

endmodule

//--- logic/id_stage.sv
/*
 * Instruction decode stage
 * Decoder, operand mux, register file and writeback control for an RV32I subset.
 */

`timescale 1ns/1ps

module id_stage (
  input  logic             clk_i,
  input  logic             rst_ni,

  // Fetch side
  input  logic             instr_valid_i,
  input  logic             instr_new_i,
  input  id_pkg::word_t    instr_rdata_i,
  input  id_pkg::word_t    pc_id_i,

  // EX stage
  input  logic             branch_decision_i,
  input  logic             ex_valid_i,
  input  id_pkg::word_t    regfile_wdata_ex_i,

  // LSU
  input  logic             lsu_valid_i,
  input  logic             lsu_load_err_i,
  input  id_pkg::word_t    regfile_wdata_lsu_i,

  output id_pkg::alu_req_t alu_req_o,
  output id_pkg::lsu_req_t lsu_req_o,
  output logic             branch_set_o,
  output logic             id_ready_o,
  output logic             instr_ret_o,
  output logic             illegal_insn_o
);

  import id_pkg::*;

  dec_ctrl_t dec_ctrl;
  imm_set_t  dec_imm;
  logic      dec_illegal;
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  reg_addr_t rf_waddr;
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  word_t     rf_wdata;
  logic      rf_we;
  logic      executing;

  id_decoder i_decoder (
    .instr_rdata_i (instr_rdata_i),
    .ctrl_o        (dec_ctrl),
    .imm_o         (dec_imm),
    .raddr_a_o     (rf_raddr_a),
    .raddr_b_o     (rf_raddr_b),
    .waddr_o       (rf_waddr),
    .illegal_o     (dec_illegal)
  );

  id_register_file i_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

  id_operand_mux i_operand_mux (
    .ctrl_i      (dec_ctrl),
    .imm_i       (dec_imm),
    .rdata_a_i   (rf_rdata_a),
    .rdata_b_i   (rf_rdata_b),
    .pc_i        (pc_id_i),
    .executing_i (executing),
    .alu_req_o   (alu_req_o),
    .lsu_req_o   (lsu_req_o)
  );

  id_wb_control i_wb_control (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_new_i       (instr_new_i),
    .illegal_i         (dec_illegal),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .lsu_load_err_i    (lsu_load_err_i),
    .ctrl_i            (dec_ctrl),
    .wdata_ex_i        (regfile_wdata_ex_i),
    .wdata_lsu_i       (regfile_wdata_lsu_i),
    .rf_we_o           (rf_we),
    .rf_wdata_o        (rf_wdata),
    .executing_o       (executing),
    .branch_set_o      (branch_set_o),
    .id_ready_o        (id_ready_o),
    .instr_ret_o       (instr_ret_o),
    .illegal_insn_o    (illegal_insn_o)
  );

endmodule

//--- sim/tb_id_clock.sv
/*
 * Testbench clock
 * Free-running clock with a 10 ns period.
 */

`timescale 1ns/1ps

module tb_id_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period of 5 ns
  always #5 clk_o = ~clk_o;

endmodule

//--- sim/tb_id_stage.sv
/*
 * Decode stage testbench
 * Replays the case file through the stage and checks ALU and LSU requests,
 * retirement, branch set and register writeback.
 */

`timescale 1ns/1ps

module tb_id_stage;

  import id_pkg::*;

  localparam int EX_LATENCY = 2;
  localparam int MAX_WAIT   = 20;
  localparam int MAX_LINES  = 200;

  logic     clk;
  logic     rst_ni;
  logic     instr_valid_i;
  logic     instr_new_i;
  word_t    instr_rdata_i;
  word_t    pc_id_i;
  logic     branch_decision_i;
  logic     ex_valid_i;
  word_t    regfile_wdata_ex_i;
  logic     lsu_valid_i;
  logic     lsu_load_err_i;
  word_t    regfile_wdata_lsu_i;
  alu_req_t alu_req;
  lsu_req_t lsu_req;
  logic     branch_set;
  logic     id_ready;
  logic     instr_ret;
  logic     illegal_insn;

  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned n_tests;
  int unsigned n_failed;
  int unsigned case_errors;
  logic        timed_out;

  tb_id_clock i_clock (
    .clk_o (clk)
  );

  id_stage i_id_stage (
    .clk_i               (clk),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .instr_new_i         (instr_new_i),
    .instr_rdata_i       (instr_rdata_i),
    .pc_id_i             (pc_id_i),
    .branch_decision_i   (branch_decision_i),
    .ex_valid_i          (ex_valid_i),
    .regfile_wdata_ex_i  (regfile_wdata_ex_i),
    .lsu_valid_i         (lsu_valid_i),
    .lsu_load_err_i      (lsu_load_err_i),
    .regfile_wdata_lsu_i (regfile_wdata_lsu_i),
    .alu_req_o           (alu_req),
    .lsu_req_o           (lsu_req),
    .branch_set_o        (branch_set),
    .id_ready_o          (id_ready),
    .instr_ret_o         (instr_ret),
    .illegal_insn_o      (illegal_insn)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      case_errors++;
      $display("ERR %s: got %08h, expected %08h", name, act, exp);
    end
  endtask

  task automatic report_failure(input string what);
    n_errors++;
    case_errors++;
    $display("%s", what);
  endtask

  task automatic close_test(input string label);
    n_tests++;
    if (case_errors != 0) begin
      n_failed++;
      $display("%s: %0d mismatches", label, case_errors);
    end else begin
      $display("%s: ok", label);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driving
  ////////////////////////////////////////////////////////////////////////////

  // New-instruction cycle sampled at the falling edge
  task automatic start_instr(input word_t instr, input word_t pc, input logic bdec,
                             input word_t ex_wdata, input word_t lsu_wdata, input logic err);
    @(posedge clk);
    instr_valid_i       <= 1'b1;
    instr_new_i         <= 1'b1;
    instr_rdata_i       <= instr;
    pc_id_i             <= pc;
    branch_decision_i   <= bdec;
    regfile_wdata_ex_i  <= ex_wdata;
    regfile_wdata_lsu_i <= lsu_wdata;
    lsu_load_err_i      <= err;
    @(negedge clk);
  endtask

  task automatic next_cycle(input logic ex_valid, input logic lsu_valid);
    @(posedge clk);
    instr_new_i <= 1'b0;
    ex_valid_i  <= ex_valid;
    lsu_valid_i <= lsu_valid;
    @(negedge clk);
  endtask

  // Idle cycle where nothing may still be active
  task automatic end_instr();
    @(posedge clk);
    instr_valid_i  <= 1'b0;
    instr_new_i    <= 1'b0;
    ex_valid_i     <= 1'b0;
    lsu_valid_i    <= 1'b0;
    lsu_load_err_i <= 1'b0;
    @(negedge clk);
    check_val("instr_ret_o", instr_ret, 1'b0);
    check_val("branch_set_o", branch_set, 1'b0);
    check_val("lsu_req_o.req", lsu_req.req, 1'b0);
    check_val("illegal_insn_o", illegal_insn, 1'b0);
  endtask

  // Completion strobe rises after valid_at stall cycles
  task automatic wait_retire(input int valid_at, input logic use_lsu, input logic exp_set);
    int   cyc;
    logic retired;
    cyc     = 0;
    retired = 1'b0;
    while (!retired && cyc < MAX_WAIT) begin
      next_cycle(!use_lsu && cyc == valid_at, use_lsu && cyc == valid_at);
      check_val("branch_set_o", branch_set, exp_set && cyc == 0);
      check_val("lsu_req_o.req", lsu_req.req, use_lsu);
      check_val("instr_ret_o", instr_ret, cyc == valid_at);
      check_val("id_ready_o", id_ready, cyc == valid_at);
      retired = instr_ret;
      cyc++;
    end
    if (!retired) begin
      report_failure($sformatf("Timeout: instruction did not retire within %0d cycles",
                               MAX_WAIT));
      timed_out = 1'b1;
    end
  endtask

  task automatic run_case(input logic [63:0] kind, input word_t instr, input word_t pc,
                          input logic bdec, input word_t ex_wdata, input word_t lsu_wdata,
                          input logic [31:0] op, input word_t opa, input word_t opb,
                          input logic [31:0] we, input logic [31:0] dtype,
                          input logic [31:0] sext, input word_t wdata);
    logic is_mem;
    int   wait_len;
    is_mem      = (kind == "load") || (kind == "loaderr") || (kind == "store");
    case_errors = 0;
    start_instr(instr, pc, bdec, ex_wdata, lsu_wdata, kind == "loaderr");
    if (kind == "illegal") begin
      check_val("illegal_insn_o", illegal_insn, 1'b1);
      check_val("instr_ret_o", instr_ret, 1'b0);
      check_val("lsu_req_o.req", lsu_req.req, 1'b0);
      check_val("id_ready_o", id_ready, 1'b1);
    end else if (is_mem || kind == "alu" || kind == "branch") begin
      check_val("illegal_insn_o", illegal_insn, 1'b0);
      check_val("alu_req_o.operator", alu_req.operator, op);
      check_val("alu_req_o.operand_a", alu_req.operand_a, opa);
      check_val("alu_req_o.operand_b", alu_req.operand_b, opb);
      check_val("branch_set_o", branch_set, 1'b0);
      if (is_mem) begin
        check_val("lsu_req_o.req", lsu_req.req, 1'b1);
        check_val("lsu_req_o.we", lsu_req.we, we);
        check_val("lsu_req_o.data_type", lsu_req.data_type, dtype);
        check_val("lsu_req_o.sign_ext", lsu_req.sign_ext, sext);
        check_val("lsu_req_o.wdata", lsu_req.wdata, wdata);
        check_val("instr_ret_o", instr_ret, 1'b0);
        check_val("id_ready_o", id_ready, 1'b0);
        wait_len = int'($urandom % 6);
        wait_retire(wait_len, 1'b1, 1'b0);
      end else if (kind == "branch" && bdec) begin
        check_val("lsu_req_o.req", lsu_req.req, 1'b0);
        check_val("instr_ret_o", instr_ret, 1'b0);
        check_val("id_ready_o", id_ready, 1'b0);
        wait_retire(EX_LATENCY, 1'b0, 1'b1);
      end else begin
        // Single-cycle ALU op or branch not taken
        check_val("lsu_req_o.req", lsu_req.req, 1'b0);
        check_val("instr_ret_o", instr_ret, 1'b1);
        check_val("id_ready_o", id_ready, 1'b1);
      end
    end else begin
      report_failure($sformatf("Unknown case kind %0s", kind));
    end
    if (!timed_out) begin
      end_instr();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int               fd;
    int               code;
    int               line_cnt;
    int unsigned      seed;
    logic [63:0]      kind;
    logic [8*160-1:0] rest;
    logic [31:0]      instr, pc, bdec, ex_wdata, lsu_wdata;
    logic [31:0]      op, opa, opb, we, dtype, sext, wdata;

    seed = 32'hae91ef05;
    void'($urandom(seed));

    n_checks    = 0;
    n_errors    = 0;
    n_tests     = 0;
    n_failed    = 0;
    case_errors = 0;
    timed_out   = 1'b0;

    rst_ni              <= 1'b0;
    instr_valid_i       <= 1'b0;
    instr_new_i         <= 1'b0;
    instr_rdata_i       <= '0;
    pc_id_i             <= '0;
    branch_decision_i   <= 1'b0;
    ex_valid_i          <= 1'b0;
    regfile_wdata_ex_i  <= '0;
    lsu_valid_i         <= 1'b0;
    lsu_load_err_i      <= 1'b0;
    regfile_wdata_lsu_i <= '0;

    repeat (16) @(posedge clk);
    rst_ni <= 1'b1;
    @(negedge clk);
    check_val("branch_set_o", branch_set, 1'b0);
    check_val("instr_ret_o", instr_ret, 1'b0);
    check_val("lsu_req_o.req", lsu_req.req, 1'b0);
    check_val("id_ready_o", id_ready, 1'b1);
    close_test("reset state");

    fd = $fopen("sim/id_cases.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the case file sim/id_cases.txt");
    end else begin
      for (line_cnt = 0; line_cnt < MAX_LINES && !timed_out; line_cnt++) begin
        code = $fscanf(fd, "%s", kind);
        if (code != 1) begin
          break;
        end
        if (kind == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", instr, pc, bdec,
                         ex_wdata, lsu_wdata, op, opa, opb, we, dtype, sext, wdata);
          if (code != 12) begin
            report_failure("Case file line has too few fields");
            break;
          end
          run_case(kind, instr, pc, bdec[0], ex_wdata, lsu_wdata, op, opa, opb,
                   we, dtype, sext, wdata);
          close_test($sformatf("case %0d %0s instr %08h", n_tests, kind, instr));
        end
      end
      $fclose(fd);
    end

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- sim/id_cases.txt
# kind instr pc bdec ex_wdata lsu_wdata alu_op op_a op_b lsu_we lsu_type lsu_sext lsu_wdata
# all values hex, the lsu columns are checked for load, loaderr and store only
alu     123450b7 00000100 0 12345000 00000000 00 00000000 12345000 0 0 0 00000000
alu     00001117 00000104 0 00001104 00000000 00 00000104 00001000 0 0 0 00000000
alu     67808193 00000108 0 12345678 00000000 00 12345000 00000678 0 0 0 00000000
alu     fff00213 0000010c 0 ffffffff 00000000 00 00000000 ffffffff 0 0 0 00000000
alu     002182b3 00000110 0 1234677c 00000000 00 12345678 00001104 0 0 0 00000000
alu     40428333 00000114 0 1234677d 00000000 01 1234677c ffffffff 0 0 0 00000000
alu     40425393 00000118 0 ffffffff 00000000 07 ffffffff 00000404 0 0 0 00000000
alu     0040b433 0000011c 0 00000001 00000000 09 12345000 ffffffff 0 0 0 00000000
alu     0f01c493 00000120 0 12345688 00000000 02 12345678 000000f0 0 0 0 00000000
alu     00508013 00000124 0 12345005 00000000 00 12345000 00000005 0 0 0 00000000
alu     00306533 00000128 0 12345678 00000000 03 00000000 12345678 0 0 0 00000000
store   00312423 0000012c 0 00000000 00000000 00 00001104 00000008 1 0 1 12345678
load    00412583 00000130 0 00000000 cafef00d 00 00001104 00000004 0 0 1 ffffffff
load    fff0c603 00000134 0 00000000 000000a5 00 12345000 ffffffff 0 2 0 00000000
loaderr 00201603 00000138 0 00000000 deadbeef 00 00000000 00000002 0 1 1 00001104
store   feb29f23 0000013c 0 00000000 00000000 00 1234677c fffffffe 1 1 1 cafef00d
alu     00c58733 00000140 0 cafef0b2 00000000 00 cafef00d 000000a5 0 0 0 00000000
alu     0076a7b3 00000144 0 00000000 00000000 08 00000000 ffffffff 0 0 0 00000000
branch  00a18863 00000148 1 00000000 00000000 0a 12345678 12345678 0 0 0 00000000
branch  fea19ce3 0000014c 0 00000000 00000000 0b 12345678 12345678 0 0 0 00000000
branch  00024263 00000150 1 00000000 00000000 0c ffffffff 00000000 0 0 0 00000000
branch  00447663 00000154 0 00000000 00000000 0f 00000001 ffffffff 0 0 0 00000000
illegal 0000086f 00000158 0 55555555 00000000 00 00000000 00000000 0 0 0 00000000
illegal 403061b3 0000015c 0 badbad00 00000000 00 00000000 00000000 0 0 0 00000000
alu     01018933 00000160 0 12345678 00000000 00 12345678 00000000 0 0 0 00000000

//--- project.f
+incdir+common
common/id_pkg.sv
decoder/id_decoder.sv
logic/id_operand_mux.sv
logic/id_register_file.sv
logic/id_wb_control.sv
logic/id_stage.sv
sim/tb_id_clock.sv
sim/tb_id_stage.sv
